// File: logic/exu_pkg.sv
package exu_pkg;

    // datapath width
    localparam int xlen = 64;
    // queue entries and so the credit count held by the sender
    localparam int queue_depth = 4;
    // doublewords of data memory
    localparam int dmem_words = 64;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [4:0] reg_addr_t;
    typedef logic [$clog2(dmem_words)-1:0] dmem_index_t;
    typedef logic [7:0] byte_mask_t;
    typedef logic [$clog2(queue_depth)-1:0] queue_ptr_t;
    // one extra bit so a full queue is representable
    typedef logic [$clog2(queue_depth+1)-1:0] queue_count_t;

    // decoded instructions
    typedef enum logic [7:0] {
        op_add = 8'd0, op_sub, op_sll, op_slt, op_sltu,
        op_xor, op_srl, op_sra, op_or, op_and,
        op_addi, op_slti, op_sltiu, op_xori, op_ori,
        op_andi, op_slli, op_srli, op_srai,
        op_addw, op_subw,
        op_lui, op_auipc,
        op_jal, op_jalr,
        op_beq, op_bne, op_blt, op_bge, op_bltu, op_bgeu,
        op_lb, op_lh, op_lw, op_ld, op_lbu, op_lhu, op_lwu,
        op_sb, op_sh, op_sw, op_sd
    } op_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_mode_t;

    typedef enum logic [3:0] {
        br_none, br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu, br_jal, br_jalr
    } branch_kind_t;

    // encoding is log2 of the access size in bytes
    typedef enum logic [1:0] {
        size_byte, size_half, size_word, size_double
    } mem_size_t;

    typedef enum logic {
        st_issue, st_load_wait
    } exu_state_t;

endpackage

// File: logic/exu_alu.sv
module exu_alu (
    input  exu_pkg::alu_mode_t alu_mode,
    input  exu_pkg::xlen_t     operand_a,
    input  exu_pkg::xlen_t     operand_b,
    input  logic               word_op,
    output exu_pkg::xlen_t     alu_result
);

    logic [5:0] shamt;
    exu_pkg::xlen_t raw;

    // rv64 shifts use six bits of amount
    assign shamt = operand_b[5:0];

    always_comb begin
        case (alu_mode)
            exu_pkg::alu_sub:  raw = operand_a - operand_b;
            exu_pkg::alu_sll:  raw = operand_a << shamt;
            exu_pkg::alu_slt:  raw = exu_pkg::xlen_t'($signed(operand_a) < $signed(operand_b));
            exu_pkg::alu_sltu: raw = exu_pkg::xlen_t'(operand_a < operand_b);
            exu_pkg::alu_xor:  raw = operand_a ^ operand_b;
            exu_pkg::alu_srl:  raw = operand_a >> shamt;
            // arithmetic shift keeps the sign bit
            exu_pkg::alu_sra:  raw = exu_pkg::xlen_t'($signed(operand_a) >>> shamt);
            exu_pkg::alu_or:   raw = operand_a | operand_b;
            exu_pkg::alu_and:  raw = operand_a & operand_b;
            default:           raw = operand_a + operand_b;
        endcase
    end

    // addw and subw sign extend bit 31 into the upper word
    assign alu_result = word_op ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

// File: logic/exu_register_file.sv
module exu_register_file (
    input  logic               clk,
    input  logic               reset,
    input  exu_pkg::reg_addr_t rs1_addr,
    input  exu_pkg::reg_addr_t rs2_addr,
    input  logic               rf_wen,
    input  exu_pkg::reg_addr_t rf_rd,
    input  exu_pkg::xlen_t     rf_wdata,
    output exu_pkg::xlen_t     rs1_data,
    output exu_pkg::xlen_t     rs2_data
);

    exu_pkg::xlen_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wen && rf_rd != '0) begin
            // x0 writes are dropped here
            regs[rf_rd] <= rf_wdata;
        end
    end

    // two async read ports with x0 pinned to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: logic/exu_branch.sv
module exu_branch (
    input  exu_pkg::branch_kind_t branch_kind,
    input  exu_pkg::xlen_t        cur_pc,
    input  exu_pkg::xlen_t        cur_imm,
    input  exu_pkg::xlen_t        rs1_data,
    input  exu_pkg::xlen_t        rs2_data,
    output exu_pkg::xlen_t        next_pc,
    output exu_pkg::xlen_t        link_addr
);

    exu_pkg::xlen_t pc_plus4, pc_target, jalr_sum;
    logic taken;

    assign pc_plus4  = cur_pc + exu_pkg::xlen_t'(4);
    assign pc_target = cur_pc + cur_imm;
    assign jalr_sum  = rs1_data + cur_imm;
    assign link_addr = pc_plus4;

    always_comb begin
        case (branch_kind)
            exu_pkg::br_eq:  taken = (rs1_data == rs2_data);
            exu_pkg::br_ne:  taken = (rs1_data != rs2_data);
            exu_pkg::br_lt:  taken = ($signed(rs1_data) < $signed(rs2_data));
            // signed greater or equal
            exu_pkg::br_ge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            exu_pkg::br_ltu: taken = (rs1_data < rs2_data);
            exu_pkg::br_geu: taken = (rs1_data >= rs2_data);
            exu_pkg::br_jal: taken = 1'b1;
            default:         taken = 1'b0;
        endcase
        // jalr target drops bit zero
        if (branch_kind == exu_pkg::br_jalr) begin
            next_pc = {jalr_sum[exu_pkg::xlen-1:1], 1'b0};
        end else begin
            next_pc = taken ? pc_target : pc_plus4;
        end
    end

endmodule

// File: logic/exu_load_store.sv
module exu_load_store (
    input  logic               clk,
    input  logic               mem_read,
    input  logic               mem_write,
    input  exu_pkg::mem_size_t mem_size,
    input  logic               load_unsigned,
    input  exu_pkg::xlen_t     mem_addr,
    input  exu_pkg::xlen_t     store_data,
    output exu_pkg::xlen_t     load_data
);

    exu_pkg::xlen_t dmem [exu_pkg::dmem_words];

    exu_pkg::dmem_index_t index;
    logic [2:0] offset;
    exu_pkg::byte_mask_t byte_mask;
    exu_pkg::xlen_t store_lanes;

    // read side state captured with the access
    exu_pkg::xlen_t read_word;
    exu_pkg::mem_size_t size_q;
    logic [2:0] offset_q;
    logic unsigned_q;
    exu_pkg::xlen_t lane;

    // index wraps at the memory size
    assign index  = mem_addr[3 +: $bits(exu_pkg::dmem_index_t)];
    assign offset = mem_addr[2:0];

    // move store bytes up to their lane
    assign store_lanes = store_data << {offset, 3'b000};

    always_comb begin
        case (mem_size)
            exu_pkg::size_byte: byte_mask = 8'h01 << offset;
            exu_pkg::size_half: byte_mask = 8'h03 << offset;
            exu_pkg::size_word: byte_mask = 8'h0f << offset;
            default:            byte_mask = 8'hff;
        endcase
    end

    always_ff @(posedge clk) begin
        if (mem_write) begin
            for (int i = 0; i < 8; i++) begin
                if (byte_mask[i]) begin
                    dmem[index][i*8 +: 8] <= store_lanes[i*8 +: 8];
                end
            end
        end
        if (mem_read) begin
            read_word  <= dmem[index];
            size_q     <= mem_size;
            offset_q   <= offset;
            unsigned_q <= load_unsigned;
        end
    end

    // addressed bytes down to bit zero
    assign lane = read_word >> {offset_q, 3'b000};

    always_comb begin
        case (size_q)
            exu_pkg::size_byte:
                load_data = {{56{lane[7] & !unsigned_q}}, lane[7:0]};
            exu_pkg::size_half:
                load_data = {{48{lane[15] & !unsigned_q}}, lane[15:0]};
            exu_pkg::size_word:
                load_data = {{32{lane[31] & !unsigned_q}}, lane[31:0]};
            default:
                load_data = lane;
        endcase
    end

    // no access may cross its natural alignment
    assert property (@(posedge clk)
        (mem_read || mem_write) |->
            (offset & ((3'd1 << mem_size) - 3'd1)) == 3'd0);

endmodule

// File: logic/exu_control.sv
module exu_control (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          instr_valid,
    input  exu_pkg::op_t                  instr_op,
    input  exu_pkg::reg_addr_t            instr_rd,
    input  exu_pkg::reg_addr_t            instr_rs1,
    input  exu_pkg::reg_addr_t            instr_rs2,
    input  exu_pkg::xlen_t                instr_imm,
    input  exu_pkg::xlen_t                instr_pc,
    input  exu_pkg::xlen_t                rs1_data,
    input  exu_pkg::xlen_t                rs2_data,
    input  exu_pkg::xlen_t                alu_result,
    input  exu_pkg::xlen_t                next_pc,
    input  exu_pkg::xlen_t                link_addr,
    input  exu_pkg::xlen_t                load_data,
    output logic                          credit_return,
    output exu_pkg::reg_addr_t            rs1_addr,
    output exu_pkg::reg_addr_t            rs2_addr,
    output exu_pkg::xlen_t                operand_a,
    output exu_pkg::xlen_t                operand_b,
    output exu_pkg::alu_mode_t            alu_mode,
    output logic                          word_op,
    output exu_pkg::branch_kind_t         branch_kind,
    output exu_pkg::xlen_t                cur_pc,
    output exu_pkg::xlen_t                cur_imm,
    output logic                          mem_read,
    output logic                          mem_write,
    output exu_pkg::mem_size_t            mem_size,
    output logic                          load_unsigned,
    output logic                          rf_wen,
    output exu_pkg::reg_addr_t            rf_rd,
    output exu_pkg::xlen_t                rf_wdata,
    output logic                          retire_valid,
    output exu_pkg::xlen_t                retire_pc,
    output exu_pkg::xlen_t                retire_next_pc,
    output logic                          retire_wen,
    output exu_pkg::reg_addr_t            retire_rd,
    output exu_pkg::xlen_t                retire_wdata
);

    // instruction queue storage
    exu_pkg::op_t       q_op  [exu_pkg::queue_depth];
    exu_pkg::reg_addr_t q_rd  [exu_pkg::queue_depth];
    exu_pkg::reg_addr_t q_rs1 [exu_pkg::queue_depth];
    exu_pkg::reg_addr_t q_rs2 [exu_pkg::queue_depth];
    exu_pkg::xlen_t     q_imm [exu_pkg::queue_depth];
    exu_pkg::xlen_t     q_pc  [exu_pkg::queue_depth];

    exu_pkg::queue_ptr_t wr_ptr, rd_ptr;
    exu_pkg::queue_count_t count;
    exu_pkg::exu_state_t state;
    exu_pkg::op_t head_op;
    logic pop, retiring, pc_src, imm_src, dec_wen, wb_link, wb_imm, dec_load, dec_store;
    exu_pkg::xlen_t wb_data, held_pc, held_next_pc;
    exu_pkg::reg_addr_t held_rd;

    // head entry is read straight out of the queue
    assign head_op  = q_op[rd_ptr];
    assign rs1_addr = q_rs1[rd_ptr];
    assign rs2_addr = q_rs2[rd_ptr];
    assign cur_pc   = q_pc[rd_ptr];
    assign cur_imm  = q_imm[rd_ptr];

    assign pop = (state == exu_pkg::st_issue) && (count != '0);
    // credit goes back as soon as the entry leaves
    assign credit_return = pop;

    always_comb begin
        case (head_op)
            exu_pkg::op_sub, exu_pkg::op_subw:   alu_mode = exu_pkg::alu_sub;
            exu_pkg::op_sll, exu_pkg::op_slli:   alu_mode = exu_pkg::alu_sll;
            exu_pkg::op_slt, exu_pkg::op_slti:   alu_mode = exu_pkg::alu_slt;
            exu_pkg::op_sltu, exu_pkg::op_sltiu: alu_mode = exu_pkg::alu_sltu;
            exu_pkg::op_xor, exu_pkg::op_xori:   alu_mode = exu_pkg::alu_xor;
            exu_pkg::op_srl, exu_pkg::op_srli:   alu_mode = exu_pkg::alu_srl;
            exu_pkg::op_sra, exu_pkg::op_srai:   alu_mode = exu_pkg::alu_sra;
            exu_pkg::op_or, exu_pkg::op_ori:     alu_mode = exu_pkg::alu_or;
            exu_pkg::op_and, exu_pkg::op_andi:   alu_mode = exu_pkg::alu_and;
            // addi, auipc and the memory address all add
            default:                             alu_mode = exu_pkg::alu_add;
        endcase
        case (head_op)
            exu_pkg::op_beq:  branch_kind = exu_pkg::br_eq;
            exu_pkg::op_bne:  branch_kind = exu_pkg::br_ne;
            exu_pkg::op_blt:  branch_kind = exu_pkg::br_lt;
            exu_pkg::op_bge:  branch_kind = exu_pkg::br_ge;
            exu_pkg::op_bltu: branch_kind = exu_pkg::br_ltu;
            exu_pkg::op_bgeu: branch_kind = exu_pkg::br_geu;
            exu_pkg::op_jal:  branch_kind = exu_pkg::br_jal;
            exu_pkg::op_jalr: branch_kind = exu_pkg::br_jalr;
            default:          branch_kind = exu_pkg::br_none;
        endcase
        case (head_op)
            exu_pkg::op_lb, exu_pkg::op_lbu, exu_pkg::op_sb: mem_size = exu_pkg::size_byte;
            exu_pkg::op_lh, exu_pkg::op_lhu, exu_pkg::op_sh: mem_size = exu_pkg::size_half;
            exu_pkg::op_lw, exu_pkg::op_lwu, exu_pkg::op_sw: mem_size = exu_pkg::size_word;
            default:                                         mem_size = exu_pkg::size_double;
        endcase
        dec_load = head_op inside {exu_pkg::op_lb, exu_pkg::op_lh, exu_pkg::op_lw,
            exu_pkg::op_ld, exu_pkg::op_lbu, exu_pkg::op_lhu, exu_pkg::op_lwu};
        dec_store = head_op inside {exu_pkg::op_sb, exu_pkg::op_sh, exu_pkg::op_sw,
            exu_pkg::op_sd};
        load_unsigned = head_op inside {exu_pkg::op_lbu, exu_pkg::op_lhu, exu_pkg::op_lwu};
        word_op = head_op inside {exu_pkg::op_addw, exu_pkg::op_subw};
        // reg-reg forms take rs2, everything else the immediate
        imm_src = !(head_op inside {exu_pkg::op_add, exu_pkg::op_sub, exu_pkg::op_sll,
            exu_pkg::op_slt, exu_pkg::op_sltu, exu_pkg::op_xor, exu_pkg::op_srl,
            exu_pkg::op_sra, exu_pkg::op_or, exu_pkg::op_and, exu_pkg::op_addw,
            exu_pkg::op_subw});
        pc_src  = (head_op == exu_pkg::op_auipc);
        wb_imm  = (head_op == exu_pkg::op_lui);
        wb_link = (branch_kind == exu_pkg::br_jal) || (branch_kind == exu_pkg::br_jalr);
        // stores and conditional branches leave the register file alone
        dec_wen = !dec_store && !(branch_kind inside {exu_pkg::br_eq, exu_pkg::br_ne,
            exu_pkg::br_lt, exu_pkg::br_ge, exu_pkg::br_ltu, exu_pkg::br_geu});
    end

    assign operand_a = pc_src ? cur_pc : rs1_data;
    assign operand_b = imm_src ? cur_imm : rs2_data;
    assign wb_data   = wb_link ? link_addr : (wb_imm ? cur_imm : alu_result);

    assign mem_read  = pop && dec_load;
    assign mem_write = pop && dec_store;

    // load writeback happens in load_wait from the held record
    assign retiring = (pop && !dec_load) || (state == exu_pkg::st_load_wait);
    assign rf_wen   = (pop && dec_wen && !dec_load) || (state == exu_pkg::st_load_wait);
    assign rf_rd    = (state == exu_pkg::st_load_wait) ? held_rd : q_rd[rd_ptr];
    assign rf_wdata = (state == exu_pkg::st_load_wait) ? load_data : wb_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            state <= exu_pkg::st_issue;
            retire_valid <= 1'b0;
        end else begin
            if (instr_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + exu_pkg::queue_count_t'(instr_valid)
                - exu_pkg::queue_count_t'(pop);
            if (mem_read) begin
                state <= exu_pkg::st_load_wait;
            end else begin
                state <= exu_pkg::st_issue;
            end
            retire_valid <= retiring;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            q_op[wr_ptr]  <= instr_op;
            q_rd[wr_ptr]  <= instr_rd;
            q_rs1[wr_ptr] <= instr_rs1;
            q_rs2[wr_ptr] <= instr_rs2;
            q_imm[wr_ptr] <= instr_imm;
            q_pc[wr_ptr]  <= instr_pc;
        end
        // park the load while its data comes back
        if (mem_read) begin
            held_rd <= q_rd[rd_ptr];
            held_pc <= cur_pc;
            held_next_pc <= next_pc;
        end
        if (retiring) begin
            retire_pc <= (state == exu_pkg::st_load_wait) ? held_pc : cur_pc;
            retire_next_pc <= (state == exu_pkg::st_load_wait) ? held_next_pc : next_pc;
            retire_wen <= rf_wen;
            retire_rd <= rf_rd;
            retire_wdata <= rf_wdata;
        end
    end

    // sender must hold a credit, so a full queue never sees a push
    assert property (@(posedge clk) disable iff (reset)
        instr_valid |-> count != exu_pkg::queue_count_t'(exu_pkg::queue_depth));

    // a load stalls issue for exactly one cycle and then retires
    assert property (@(posedge clk) disable iff (reset)
        mem_read |=> (state == exu_pkg::st_load_wait) ##1
            (state == exu_pkg::st_issue && retire_valid));

endmodule

// File: logic/exu_top.sv
module exu_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 instr_valid,
    input  exu_pkg::op_t         instr_op,
    input  exu_pkg::reg_addr_t   instr_rd,
    input  exu_pkg::reg_addr_t   instr_rs1,
    input  exu_pkg::reg_addr_t   instr_rs2,
    input  exu_pkg::xlen_t       instr_imm,
    input  exu_pkg::xlen_t       instr_pc,
    output logic                 credit_return,
    output logic                 retire_valid,
    output exu_pkg::xlen_t       retire_pc,
    output exu_pkg::xlen_t       retire_next_pc,
    output logic                 retire_wen,
    output exu_pkg::reg_addr_t   retire_rd,
    output exu_pkg::xlen_t       retire_wdata
);

    exu_pkg::reg_addr_t rs1_addr, rs2_addr, rf_rd;
    exu_pkg::xlen_t rs1_data, rs2_data, rf_wdata;
    exu_pkg::xlen_t operand_a, operand_b, alu_result;
    exu_pkg::xlen_t cur_pc, cur_imm, next_pc, link_addr, load_data;
    exu_pkg::alu_mode_t alu_mode;
    exu_pkg::branch_kind_t branch_kind;
    exu_pkg::mem_size_t mem_size;
    logic word_op, mem_read, mem_write, load_unsigned, rf_wen;

    exu_control u_control (.*);

    exu_register_file u_register_file (
        .clk(clk), .reset(reset),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rf_wen(rf_wen), .rf_rd(rf_rd), .rf_wdata(rf_wdata),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    exu_alu u_alu (
        .alu_mode(alu_mode), .operand_a(operand_a), .operand_b(operand_b),
        .word_op(word_op), .alu_result(alu_result)
    );

    exu_branch u_branch (
        .branch_kind(branch_kind), .cur_pc(cur_pc), .cur_imm(cur_imm),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .next_pc(next_pc), .link_addr(link_addr)
    );

    // address comes from the alu add of rs1 and imm
    exu_load_store u_load_store (
        .clk(clk), .mem_read(mem_read), .mem_write(mem_write),
        .mem_size(mem_size), .load_unsigned(load_unsigned),
        .mem_addr(alu_result), .store_data(rs2_data), .load_data(load_data)
    );

endmodule

// File: tests/exu_tb.sv
module exu_tb;

    logic clk;
    logic reset;
    logic instr_valid;
    exu_pkg::op_t instr_op;
    exu_pkg::reg_addr_t instr_rd, instr_rs1, instr_rs2;
    exu_pkg::xlen_t instr_imm, instr_pc;
    logic credit_return, retire_valid, retire_wen;
    exu_pkg::xlen_t retire_pc, retire_next_pc, retire_wdata;
    exu_pkg::reg_addr_t retire_rd;

    // one entry per program line
    exu_pkg::op_t op_q[$];
    exu_pkg::reg_addr_t rd_q[$], rs1_q[$], rs2_q[$];
    exu_pkg::xlen_t imm_q[$], pc_q[$], wdata_q[$], next_pc_q[$];
    bit wen_q[$];
    // line indices issued but not yet retired
    int scoreboard[$];

    int n_lines, issued, retired, returned, credits;
    int value_errors, protocol_errors;
    bit loaded;
    logic [15:0] lfsr;

    exu_top u_exu_top (.*);

    always #2 clk = ~clk;

    // 16-bit galois lfsr with taps at 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
    endfunction

    // op names in the file drop the op_ prefix
    function automatic bit lookup_op(input string name, output exu_pkg::op_t op);
        exu_pkg::op_t e;
        e = e.first();
        op = e;
        lookup_op = 1'b0;
        repeat (e.num()) begin
            if (e.name() == {"op_", name}) begin
                op = e;
                lookup_op = 1'b1;
            end
            e = e.next();
        end
    endfunction

    task automatic load_program();
        int fd, n, rd, rs1, rs2, wen;
        string line, name;
        exu_pkg::xlen_t imm, pc, wdata, npc;
        exu_pkg::op_t op;
        fd = $fopen("tests/exu_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/exu_input.txt");
            protocol_errors++;
        end else begin
            while ($fgets(line, fd)) begin
                n = $sscanf(line, "%s %d %d %d %h %h %d %h %h",
                    name, rd, rs1, rs2, imm, pc, wen, wdata, npc);
                if (n == 9 && lookup_op(name, op)) begin
                    op_q.push_back(op);
                    rd_q.push_back(exu_pkg::reg_addr_t'(rd));
                    rs1_q.push_back(exu_pkg::reg_addr_t'(rs1));
                    rs2_q.push_back(exu_pkg::reg_addr_t'(rs2));
                    imm_q.push_back(imm);
                    pc_q.push_back(pc);
                    wen_q.push_back(bit'(wen));
                    wdata_q.push_back(wdata);
                    next_pc_q.push_back(npc);
                end else if (n > 0 && name != "#") begin
                    $display("unreadable program line: %s", line);
                    protocol_errors++;
                end
            end
            $fclose(fd);
        end
        n_lines = op_q.size();
    endtask

    task automatic compare_xlen(input string field, input exu_pkg::xlen_t got,
                                input exu_pkg::xlen_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, field, got, exp);
        end
    endtask

    task automatic compare_reg_addr(input string field, input exu_pkg::reg_addr_t got,
                                    input exu_pkg::reg_addr_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: %s is x%0d, expected x%0d", $time, field, got, exp);
        end
    endtask

    task automatic compare_flag(input string field, input bit got, input bit exp);
        if (got !== exp) begin
            value_errors++;
            $display("[ERROR] %0t: %s is %0b, expected %0b", $time, field, got, exp);
        end
    endtask

    // oldest outstanding line must match the record
    task automatic check_retire();
        int idx;
        string tag;
        if (scoreboard.size() == 0) begin
            protocol_errors++;
            $display("retire record at %0t with no instruction outstanding", $time);
        end else begin
            idx = scoreboard.pop_front();
            tag = $sformatf("line %0d", idx);
            compare_xlen({tag, " retire_pc"}, retire_pc, pc_q[idx]);
            compare_xlen({tag, " retire_next_pc"}, retire_next_pc, next_pc_q[idx]);
            compare_flag({tag, " retire_wen"}, retire_wen, wen_q[idx]);
            compare_reg_addr({tag, " retire_rd"}, retire_rd, rd_q[idx]);
            // data only means something when a register is written
            if (wen_q[idx]) begin
                compare_xlen({tag, " retire_wdata"}, retire_wdata, wdata_q[idx]);
            end
            retired++;
        end
    endtask

    // sample last cycle's outputs, then drive the next one
    task automatic step_cycle();
        if (issued == 0 && (retire_valid || credit_return)) begin
            protocol_errors++;
            $display("DUT output active at %0t before any instruction was issued", $time);
        end
        if (credit_return) begin
            credits++;
            returned++;
        end
        if (credits > exu_pkg::queue_depth) begin
            protocol_errors++;
            $display("more credits came back than were spent, at %0t", $time);
        end
        if (retire_valid) begin
            check_retire();
        end
        instr_valid <= 1'b0;
        if (issued < n_lines && credits > 0) begin
            lfsr = lfsr_next(lfsr);
            if (lfsr[0]) begin
                instr_valid <= 1'b1;
                instr_op <= op_q[issued];
                instr_rd <= rd_q[issued];
                instr_rs1 <= rs1_q[issued];
                instr_rs2 <= rs2_q[issued];
                instr_imm <= imm_q[issued];
                instr_pc <= pc_q[issued];
                scoreboard.push_back(issued);
                issued++;
                credits--;
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        instr_valid = 1'b0;
        instr_op = exu_pkg::op_add;
        instr_rd = '0;
        instr_rs1 = '0;
        instr_rs2 = '0;
        instr_imm = '0;
        instr_pc = '0;
        credits = exu_pkg::queue_depth;
        lfsr = 16'd93;
        load_program();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        while (retired < n_lines) begin
            @(posedge clk);
            step_cycle();
        end
        // nothing more may retire or return a credit after the last retire
        repeat (4) begin
            @(posedge clk);
            step_cycle();
        end
        if (returned != issued) begin
            protocol_errors++;
            $display("%0d credits returned for %0d issued instructions", returned, issued);
        end
        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // bound scales with program length
    initial begin
        wait (loaded);
        repeat (n_lines * 16 + 40) @(posedge clk);
        $display("timeout: only %0d of %0d instructions retired", retired, n_lines);
        $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
        $display("Errors found");
        $finish;
    end

endmodule

// File: sources.f
logic/exu_pkg.sv
logic/exu_alu.sv
logic/exu_register_file.sv
logic/exu_branch.sv
logic/exu_load_store.sv
logic/exu_control.sv
logic/exu_top.sv
tests/exu_tb.sv

// File: tests/exu_input.txt
# op rd rs1 rs2 imm pc expected_wen expected_wdata expected_next_pc (numbers after rs2 in hex)
addi  1  0  0 0000000000000100 1000 1 0000000000000100 1004
addi  2  0  0 fffffffffffffffb 1004 1 fffffffffffffffb 1008
add   3  1  2 0000000000000000 1008 1 00000000000000fb 100c
sub   4  1  2 0000000000000000 100c 1 0000000000000105 1010
lui   5  0  0 ffffffff80000000 1010 1 ffffffff80000000 1014
subw  6  5  1 0000000000000000 1014 1 000000007fffff00 1018
addw  7  6  6 0000000000000000 1018 1 fffffffffffffe00 101c
auipc 8  0  0 0000000000002000 101c 1 000000000000301c 1020
slt   9  2  1 0000000000000000 1020 1 0000000000000001 1024
srai  10 2  0 0000000000000001 1024 1 fffffffffffffffd 1028
addi  0  1  0 0000000000000001 1028 1 0000000000000101 102c
add   11 0  3 0000000000000000 102c 1 00000000000000fb 1030
beq   0  1  1 0000000000000010 1030 0 0000000000000000 1040
beq   0  1  2 0000000000000010 1034 0 0000000000000000 1038
bne   0  1  2 0000000000000010 1038 0 0000000000000000 1048
bne   0  1  1 0000000000000010 103c 0 0000000000000000 1040
blt   0  2  1 fffffffffffffff0 1040 0 0000000000000000 1030
blt   0  1  2 0000000000000010 1044 0 0000000000000000 1048
bge   0  1  2 0000000000000010 1048 0 0000000000000000 1058
bge   0  2  1 0000000000000010 104c 0 0000000000000000 1050
bltu  0  1  2 0000000000000010 1050 0 0000000000000000 1060
bltu  0  2  1 0000000000000010 1054 0 0000000000000000 1058
bgeu  0  2  1 0000000000000010 1058 0 0000000000000000 1068
bgeu  0  1  2 0000000000000010 105c 0 0000000000000000 1060
jal   12 0  0 0000000000000100 1060 1 0000000000001064 1160
jalr  13 1  0 0000000000000021 1064 1 0000000000001068 0120
sd    0  1  6 0000000000000000 1068 0 0000000000000000 106c
sw    0  1  2 0000000000000004 106c 0 0000000000000000 1070
sh    0  1  2 000000000000000a 1070 0 0000000000000000 1074
sb    0  1  2 000000000000000f 1074 0 0000000000000000 1078
ld    20 1  0 0000000000000000 1078 1 fffffffb7fffff00 107c
lw    21 1  0 0000000000000004 107c 1 fffffffffffffffb 1080
lwu   22 1  0 0000000000000004 1080 1 00000000fffffffb 1084
lh    23 1  0 000000000000000a 1084 1 fffffffffffffffb 1088
lhu   24 1  0 000000000000000a 1088 1 000000000000fffb 108c
lb    25 1  0 000000000000000f 108c 1 fffffffffffffffb 1090
lbu   26 1  0 000000000000000f 1090 1 00000000000000fb 1094
